// File: csr_pkg.sv
package csr_pkg;

    // Data widths
    typedef logic [31:0] xlen_t;     // One machine word
    typedef logic [63:0] dword_t;    // Timer values
    typedef logic [11:0] csr_addr_t; // Raw CSR address

    // Privilege levels, 2 is reserved
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } priv_mode_t;

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1, // csrrw
        CSR_S     = 3'd2, // csrrs
        CSR_C     = 3'd3, // csrrc
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_t;

    // Implemented CSRs
    typedef enum logic [11:0] {
        ADDR_SSTATUS  = 12'h100,
        ADDR_SIE      = 12'h104,
        ADDR_STVEC    = 12'h105,
        ADDR_SSCRATCH = 12'h140,
        ADDR_SEPC     = 12'h141,
        ADDR_SCAUSE   = 12'h142,
        ADDR_SIP      = 12'h144,
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,
        ADDR_MEDELEG  = 12'h302,
        ADDR_MIDELEG  = 12'h303,
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344
    } csr_addr_e;

    // Low two bits of xtvec
    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'd0,
        TVEC_VECTORED = 2'd1
    } tvec_mode_t;

    // Interrupt codes, same as the mip/mie/mideleg bit index
    localparam int IRQ_SSI = 1;
    localparam int IRQ_STI = 5;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_SEI = 9;

    localparam int CAUSE_ECALL_U  = 8;  // Plus current mode
    localparam int CAUSE_INTR_BIT = 31;

    // MXL=1, extensions U S M I A
    localparam xlen_t MISA_VALUE = 32'h4014_1101;

    localparam int MSTATUS_SIE    = 1;
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_SPIE   = 5;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_SPP    = 8;
    localparam int MSTATUS_MPP_LO = 11; // MPP is 12:11

    localparam xlen_t SSTATUS_MASK = 32'h0000_0122; // SPP, SPIE, SIE
    localparam xlen_t SIP_MASK     = 32'h0000_0222; // SEI, STI, SSI

endpackage

// File: csr_access.sv
`timescale 1ns/1ps

module csr_access (
    input  logic                 csr_valid,
    input  csr_pkg::csr_cmd_t    csr_cmd,
    input  csr_pkg::csr_addr_t   csr_addr,
    input  csr_pkg::xlen_t       csr_wsrc,
    input  logic                 trap_take,
    input  csr_pkg::priv_mode_t  priv_mode,
    input  csr_pkg::xlen_t       mstatus,
    input  csr_pkg::xlen_t       medeleg,
    input  csr_pkg::xlen_t       mideleg,
    input  csr_pkg::xlen_t       mie,
    input  csr_pkg::xlen_t       mip,
    input  csr_pkg::xlen_t       mtvec,
    input  csr_pkg::xlen_t       stvec,
    input  csr_pkg::xlen_t       mscratch,
    input  csr_pkg::xlen_t       sscratch,
    input  csr_pkg::xlen_t       mepc,
    input  csr_pkg::xlen_t       sepc,
    input  csr_pkg::xlen_t       mcause,
    input  csr_pkg::xlen_t       scause,
    output csr_pkg::xlen_t       csr_rdata,
    output logic                 wr_en,
    output csr_pkg::xlen_t       wdata
);

    logic           can_access; // Addr[9:8] is the lowest mode allowed
    logic           read_only;  // Addr[11:10] == 3 marks read-only space
    logic           is_write;
    csr_pkg::xlen_t rdata_raw;

    assign can_access = csr_addr[9:8] <= priv_mode;
    assign read_only  = csr_addr[11:10] == 2'b11;
    assign is_write   = (csr_cmd == csr_pkg::CSR_W) || (csr_cmd == csr_pkg::CSR_S) ||
                        (csr_cmd == csr_pkg::CSR_C);

    // Read mux
    always_comb begin
        case (csr_addr)
            csr_pkg::ADDR_SSTATUS:  rdata_raw = mstatus & csr_pkg::SSTATUS_MASK; // S view
            csr_pkg::ADDR_SIE:      rdata_raw = mie & csr_pkg::SIP_MASK;
            csr_pkg::ADDR_STVEC:    rdata_raw = stvec;
            csr_pkg::ADDR_SSCRATCH: rdata_raw = sscratch;
            csr_pkg::ADDR_SEPC:     rdata_raw = sepc;
            csr_pkg::ADDR_SCAUSE:   rdata_raw = scause;
            csr_pkg::ADDR_SIP:      rdata_raw = mip & csr_pkg::SIP_MASK;
            csr_pkg::ADDR_MSTATUS:  rdata_raw = mstatus;
            csr_pkg::ADDR_MISA:     rdata_raw = csr_pkg::MISA_VALUE; // Constant
            csr_pkg::ADDR_MEDELEG:  rdata_raw = medeleg;
            csr_pkg::ADDR_MIDELEG:  rdata_raw = mideleg;
            csr_pkg::ADDR_MIE:      rdata_raw = mie;
            csr_pkg::ADDR_MTVEC:    rdata_raw = mtvec;
            csr_pkg::ADDR_MSCRATCH: rdata_raw = mscratch;
            csr_pkg::ADDR_MEPC:     rdata_raw = mepc;
            csr_pkg::ADDR_MCAUSE:   rdata_raw = mcause;
            csr_pkg::ADDR_MIP:      rdata_raw = mip;
            default:                rdata_raw = '0; // Unknown address
        endcase
    end

    // Too low a mode reads as zero
    assign csr_rdata = can_access ? rdata_raw : '0;

    // Modify from the visible value
    always_comb begin
        case (csr_cmd)
            csr_pkg::CSR_W: wdata = csr_wsrc;
            csr_pkg::CSR_S: wdata = csr_rdata | csr_wsrc;  // Set bits
            csr_pkg::CSR_C: wdata = csr_rdata & ~csr_wsrc; // Clear bits
            default:        wdata = '0;
        endcase
    end

    // A trap in the same cycle wins over the write
    assign wr_en = csr_valid && is_write && can_access && !read_only && !trap_take;

endmodule

// File: trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                 csr_valid,
    input  csr_pkg::csr_cmd_t    csr_cmd,
    input  csr_pkg::priv_mode_t  priv_mode,
    input  csr_pkg::xlen_t       mstatus,
    input  csr_pkg::xlen_t       medeleg,
    input  csr_pkg::xlen_t       mideleg,
    input  csr_pkg::xlen_t       mie,
    input  csr_pkg::xlen_t       mip,
    input  csr_pkg::xlen_t       mtvec,
    input  csr_pkg::xlen_t       stvec,
    input  csr_pkg::xlen_t       mepc,
    input  csr_pkg::xlen_t       sepc,
    output logic                 trap_take,
    output logic                 trap_to_m,
    output csr_pkg::xlen_t       trap_cause,
    output logic                 xret_m,
    output logic                 xret_s,
    output logic                 csr_trap_flg,
    output csr_pkg::xlen_t       csr_trap_vector
);

    csr_pkg::xlen_t irq_pend;
    logic           irq_any;
    logic [4:0]     irq_code;
    logic           irq_to_m;
    logic           m_enabled;
    logic           s_enabled;
    logic           irq_take;
    logic           is_ecall;
    csr_pkg::xlen_t ecall_cause;
    logic           ecall_to_m;
    csr_pkg::xlen_t tvec;
    csr_pkg::xlen_t tvec_base;

    assign irq_pend = mip & mie; // Pending and individually enabled

    // Fixed priority MTI > SEI > SSI > STI
    always_comb begin
        irq_any  = 1'b1;
        irq_code = 5'd0;
        if (irq_pend[csr_pkg::IRQ_MTI])      irq_code = 5'(csr_pkg::IRQ_MTI);
        else if (irq_pend[csr_pkg::IRQ_SEI]) irq_code = 5'(csr_pkg::IRQ_SEI);
        else if (irq_pend[csr_pkg::IRQ_SSI]) irq_code = 5'(csr_pkg::IRQ_SSI);
        else if (irq_pend[csr_pkg::IRQ_STI]) irq_code = 5'(csr_pkg::IRQ_STI);
        else                                 irq_any  = 1'b0;
    end

    // M never traps down to S
    assign irq_to_m  = (priv_mode == csr_pkg::M_MODE) || !mideleg[irq_code];
    assign m_enabled = (priv_mode != csr_pkg::M_MODE) || mstatus[csr_pkg::MSTATUS_MIE];
    assign s_enabled = (priv_mode == csr_pkg::U_MODE) ||
                       ((priv_mode == csr_pkg::S_MODE) && mstatus[csr_pkg::MSTATUS_SIE]);
    assign irq_take  = irq_any && (irq_to_m ? m_enabled : s_enabled);

    assign is_ecall    = csr_cmd == csr_pkg::CSR_ECALL;
    assign ecall_cause = csr_pkg::CAUSE_ECALL_U + {30'd0, priv_mode}; // 8, 9 or 11
    assign ecall_to_m  = (priv_mode == csr_pkg::M_MODE) || !medeleg[ecall_cause[4:0]];

    assign trap_take = csr_valid && (is_ecall || irq_take); // ECALL first
    assign trap_to_m = is_ecall ? ecall_to_m : irq_to_m;

    always_comb begin
        if (is_ecall) begin
            trap_cause = ecall_cause;
        end else begin
            trap_cause                          = {27'd0, irq_code};
            trap_cause[csr_pkg::CAUSE_INTR_BIT] = 1'b1; // Interrupt flag
        end
    end

    // A pending interrupt preempts the return
    assign xret_m = csr_valid && !trap_take && (csr_cmd == csr_pkg::CSR_MRET);
    assign xret_s = csr_valid && !trap_take && (csr_cmd == csr_pkg::CSR_SRET);

    assign tvec      = trap_to_m ? mtvec : stvec;
    assign tvec_base = {tvec[31:2], 2'b00};

    always_comb begin
        if (trap_take) begin
            if (!is_ecall && (tvec[1:0] == csr_pkg::TVEC_VECTORED))
                csr_trap_vector = tvec_base + {25'd0, irq_code, 2'b00}; // Base + 4*code
            else
                csr_trap_vector = tvec_base;
        end else if (xret_m) begin
            csr_trap_vector = mepc;
        end else if (xret_s) begin
            csr_trap_vector = sepc;
        end else begin
            csr_trap_vector = '0;
        end
    end

    assign csr_trap_flg = trap_take || xret_m || xret_s;

endmodule

// File: csr_regs.sv
`timescale 1ns/1ps

module csr_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_valid,
    input  csr_pkg::xlen_t       csr_pc,
    input  csr_pkg::dword_t      mtime,
    input  csr_pkg::dword_t      mtimecmp,
    input  logic                 wr_en,
    input  csr_pkg::csr_addr_t   csr_addr,
    input  csr_pkg::xlen_t       wdata,
    input  logic                 trap_take,
    input  logic                 trap_to_m,
    input  csr_pkg::xlen_t       trap_cause,
    input  logic                 xret_m,
    input  logic                 xret_s,
    output csr_pkg::priv_mode_t  priv_mode,
    output csr_pkg::xlen_t       mstatus,
    output csr_pkg::xlen_t       medeleg,
    output csr_pkg::xlen_t       mideleg,
    output csr_pkg::xlen_t       mie,
    output csr_pkg::xlen_t       mip,
    output csr_pkg::xlen_t       mtvec,
    output csr_pkg::xlen_t       stvec,
    output csr_pkg::xlen_t       mscratch,
    output csr_pkg::xlen_t       sscratch,
    output csr_pkg::xlen_t       mepc,
    output csr_pkg::xlen_t       sepc,
    output csr_pkg::xlen_t       mcause,
    output csr_pkg::xlen_t       scause
);

    // mstatus fields
    logic                st_sie;
    logic                st_mie;
    logic                st_spie;
    logic                st_mpie;
    logic                st_spp;
    csr_pkg::priv_mode_t st_mpp;

    csr_pkg::xlen_t mip_s; // Software-written S bits
    logic           mtip;  // Timer compare, one cycle behind

    always_comb begin
        mstatus                                    = '0;
        mstatus[csr_pkg::MSTATUS_SIE]              = st_sie;
        mstatus[csr_pkg::MSTATUS_MIE]              = st_mie;
        mstatus[csr_pkg::MSTATUS_SPIE]             = st_spie;
        mstatus[csr_pkg::MSTATUS_MPIE]             = st_mpie;
        mstatus[csr_pkg::MSTATUS_SPP]              = st_spp;
        mstatus[csr_pkg::MSTATUS_MPP_LO +: 2]      = st_mpp;
    end

    always_comb begin
        mip                   = mip_s;
        mip[csr_pkg::IRQ_MTI] = mtip;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            priv_mode <= csr_pkg::M_MODE;
            st_sie    <= 1'b0;
            st_mie    <= 1'b0;
            st_spie   <= 1'b0;
            st_mpie   <= 1'b0;
            st_spp    <= 1'b0;
            st_mpp    <= csr_pkg::M_MODE;
            medeleg   <= '0;
            mideleg   <= '0;
            mie       <= '0;
            mip_s     <= '0;
            mtip      <= 1'b0;
            mtvec     <= '0;
            stvec     <= '0;
            mscratch  <= '0;
            sscratch  <= '0;
            mepc      <= '0;
            sepc      <= '0;
            mcause    <= '0;
            scause    <= '0;
        end else begin
            if (!trap_take)
                mtip <= mtime >= mtimecmp; // Sampled every cycle
            if (csr_valid) begin
                if (trap_take) begin
                    if (trap_to_m) begin
                        priv_mode <= csr_pkg::M_MODE;
                        mcause    <= trap_cause;
                        mepc      <= csr_pc;
                        st_mpie   <= st_mie;
                        st_mie    <= 1'b0;
                        st_mpp    <= priv_mode; // Mode we came from
                    end else begin
                        priv_mode <= csr_pkg::S_MODE;
                        scause    <= trap_cause;
                        sepc      <= csr_pc;
                        st_spie   <= st_sie;
                        st_sie    <= 1'b0;
                        st_spp    <= priv_mode[0]; // Only U or S here
                    end
                    // Acknowledge the taken interrupt
                    if (trap_cause[csr_pkg::CAUSE_INTR_BIT]) begin
                        if (trap_cause[4:0] == 5'(csr_pkg::IRQ_MTI))
                            mtip <= 1'b0;
                        else
                            mip_s[trap_cause[4:0]] <= 1'b0;
                    end
                end else if (xret_m) begin
                    priv_mode <= st_mpp;
                    st_mie    <= st_mpie;
                    st_mpie   <= 1'b1;
                    st_mpp    <= csr_pkg::U_MODE;
                end else if (xret_s) begin
                    priv_mode <= st_spp ? csr_pkg::S_MODE : csr_pkg::U_MODE;
                    st_sie    <= st_spie;
                    st_spie   <= 1'b1;
                    st_spp    <= 1'b0;
                end else if (wr_en) begin
                    case (csr_addr)
                        csr_pkg::ADDR_MSTATUS: begin
                            st_sie  <= wdata[csr_pkg::MSTATUS_SIE];
                            st_mie  <= wdata[csr_pkg::MSTATUS_MIE];
                            st_spie <= wdata[csr_pkg::MSTATUS_SPIE];
                            st_mpie <= wdata[csr_pkg::MSTATUS_MPIE];
                            st_spp  <= wdata[csr_pkg::MSTATUS_SPP];
                            if (wdata[csr_pkg::MSTATUS_MPP_LO +: 2] != 2'b10) // Reserved kept
                                st_mpp <= csr_pkg::priv_mode_t'(
                                    wdata[csr_pkg::MSTATUS_MPP_LO +: 2]);
                        end
                        csr_pkg::ADDR_SSTATUS: begin
                            st_sie  <= wdata[csr_pkg::MSTATUS_SIE];
                            st_spie <= wdata[csr_pkg::MSTATUS_SPIE];
                            st_spp  <= wdata[csr_pkg::MSTATUS_SPP];
                        end
                        csr_pkg::ADDR_MEDELEG:  medeleg <= wdata;
                        csr_pkg::ADDR_MIDELEG:  mideleg <= wdata & csr_pkg::SIP_MASK; // S irqs only
                        csr_pkg::ADDR_MIE:
                            mie <= wdata & (csr_pkg::SIP_MASK | (32'd1 << csr_pkg::IRQ_MTI));
                        csr_pkg::ADDR_SIE: // Leaves MTIE alone
                            mie <= (mie & ~csr_pkg::SIP_MASK) | (wdata & csr_pkg::SIP_MASK);
                        csr_pkg::ADDR_MIP, csr_pkg::ADDR_SIP:
                            mip_s <= wdata & csr_pkg::SIP_MASK; // MTIP not writable
                        csr_pkg::ADDR_MTVEC:    mtvec    <= wdata;
                        csr_pkg::ADDR_STVEC:    stvec    <= wdata;
                        csr_pkg::ADDR_MSCRATCH: mscratch <= wdata;
                        csr_pkg::ADDR_SSCRATCH: sscratch <= wdata;
                        csr_pkg::ADDR_MEPC:     mepc     <= {wdata[31:2], 2'b00};
                        csr_pkg::ADDR_SEPC:     sepc     <= wdata;
                        csr_pkg::ADDR_MCAUSE:   mcause   <= wdata;
                        csr_pkg::ADDR_SCAUSE:   scause   <= wdata;
                        default: ; // misa and unknown addresses ignore writes
                    endcase
                end
            end
        end
    end

endmodule

// File: csr_stage.sv
`timescale 1ns/1ps

module csr_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_valid,
    input  csr_pkg::xlen_t       csr_pc,
    input  csr_pkg::csr_cmd_t    csr_cmd,
    input  csr_pkg::csr_addr_t   csr_addr,
    input  csr_pkg::xlen_t       csr_wsrc,
    input  csr_pkg::dword_t      mtime,
    input  csr_pkg::dword_t      mtimecmp,
    output csr_pkg::xlen_t       csr_rdata,
    output logic                 csr_trap_flg,
    output csr_pkg::xlen_t       csr_trap_vector,
    output csr_pkg::priv_mode_t  priv_mode
);

    // Register state out of csr_regs
    csr_pkg::xlen_t mstatus;
    csr_pkg::xlen_t medeleg;
    csr_pkg::xlen_t mideleg;
    csr_pkg::xlen_t mie;
    csr_pkg::xlen_t mip;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t stvec;
    csr_pkg::xlen_t mscratch;
    csr_pkg::xlen_t sscratch;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t sepc;
    csr_pkg::xlen_t mcause;
    csr_pkg::xlen_t scause;

    // Write path
    logic           wr_en;
    csr_pkg::xlen_t wdata;

    // Trap path
    logic           trap_take;
    logic           trap_to_m;
    csr_pkg::xlen_t trap_cause;
    logic           xret_m;
    logic           xret_s;

    csr_access u_access (
        .csr_valid, .csr_cmd, .csr_addr, .csr_wsrc, .trap_take, .priv_mode,
        .mstatus, .medeleg, .mideleg, .mie, .mip, .mtvec, .stvec,
        .mscratch, .sscratch, .mepc, .sepc, .mcause, .scause,
        .csr_rdata, .wr_en, .wdata
    );

    trap_ctrl u_trap (
        .csr_valid, .csr_cmd, .priv_mode,
        .mstatus, .medeleg, .mideleg, .mie, .mip, .mtvec, .stvec, .mepc, .sepc,
        .trap_take, .trap_to_m, .trap_cause, .xret_m, .xret_s,
        .csr_trap_flg, .csr_trap_vector
    );

    csr_regs u_regs (
        .clk, .reset, .csr_valid, .csr_pc, .mtime, .mtimecmp,
        .wr_en, .csr_addr, .wdata,
        .trap_take, .trap_to_m, .trap_cause, .xret_m, .xret_s,
        .priv_mode, .mstatus, .medeleg, .mideleg, .mie, .mip, .mtvec, .stvec,
        .mscratch, .sscratch, .mepc, .sepc, .mcause, .scause
    );

endmodule

// File: csr_stage_props.sv
`timescale 1ns/1ps

module csr_stage_props (
    input logic                clk,
    input logic                reset,
    input logic                csr_valid,
    input logic                csr_trap_flg,
    input csr_pkg::priv_mode_t priv_mode
);

    // Trap or xRET only on a valid command
    a_flg_needs_valid: assert property (@(posedge clk) disable iff (reset)
        csr_trap_flg |-> csr_valid)
        else $error("trap flag raised without csr_valid");

    a_priv_legal: assert property (@(posedge clk) disable iff (reset)
        priv_mode != 2'd2) // Reserved encoding
        else $error("priv_mode holds the reserved value");

    // Mode moves only after a trap or return
    a_priv_change: assert property (@(posedge clk) disable iff (reset)
        (priv_mode != $past(priv_mode)) |-> $past(csr_trap_flg))
        else $error("priv_mode changed without a trap or return");

endmodule

bind csr_stage csr_stage_props u_props (
    .clk, .reset, .csr_valid, .csr_trap_flg, .priv_mode
);

// File: tb_csr_stage.sv
`timescale 1ns/1ps

module tb_csr_stage;

    // Expected misa with MXL=1 (RV32) and extensions A I M S U
    localparam logic [31:0] MISA_EXP = (32'd1 << 30) | (32'd1 << 0) | (32'd1 << 8) |
                                       (32'd1 << 12) | (32'd1 << 18) | (32'd1 << 20);
    localparam logic [31:0] INTR = 32'h8000_0000; // Interrupt flag of a cause word

    logic                clk;
    logic                reset;
    logic                csr_valid;
    csr_pkg::xlen_t      csr_pc;
    csr_pkg::csr_cmd_t   csr_cmd;
    csr_pkg::csr_addr_t  csr_addr;
    csr_pkg::xlen_t      csr_wsrc;
    csr_pkg::dword_t     mtime;
    csr_pkg::dword_t     mtimecmp;
    csr_pkg::xlen_t      csr_rdata;
    logic                csr_trap_flg;
    csr_pkg::xlen_t      csr_trap_vector;
    csr_pkg::priv_mode_t priv_mode;

    integer         seed;
    csr_pkg::xlen_t last_rdata;  // Outputs seen in the command cycle
    logic           last_flg;
    csr_pkg::xlen_t last_vec;
    csr_pkg::xlen_t scratch_exp; // Model of mscratch

    csr_stage uut (
        .clk, .reset, .csr_valid, .csr_pc, .csr_cmd, .csr_addr, .csr_wsrc,
        .mtime, .mtimecmp, .csr_rdata, .csr_trap_flg, .csr_trap_vector, .priv_mode
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %08h actual %08h", name, expected, actual);
            stop_run();
        end
    endtask

    // One valid command with outputs captured mid low phase
    task automatic run_cmd(input csr_pkg::csr_cmd_t cmd, input csr_pkg::csr_addr_t addr,
                           input csr_pkg::xlen_t wsrc, input csr_pkg::xlen_t pc);
        @(negedge clk);
        csr_valid = 1'b1;
        csr_cmd   = cmd;
        csr_addr  = addr;
        csr_wsrc  = wsrc;
        csr_pc    = pc;
        #2;
        last_rdata = csr_rdata;
        last_flg   = csr_trap_flg;
        last_vec   = csr_trap_vector;
        @(negedge clk); // State updated at the posedge in between
        csr_valid = 1'b0;
        csr_cmd   = csr_pkg::CSR_NONE;
    endtask

    // Read without valid so nothing changes
    task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::xlen_t data);
        @(negedge clk);
        csr_valid = 1'b0;
        csr_cmd   = csr_pkg::CSR_NONE;
        csr_addr  = addr;
        #2;
        data = csr_rdata;
        check_value("idle_no_flag", 32'd0, {31'd0, csr_trap_flg});
    endtask

    task automatic wait_mode(input string name, input csr_pkg::priv_mode_t mode);
        int cycles;
        cycles = 0;
        while (priv_mode !== mode && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (priv_mode !== mode) begin
            $display("Timeout in %s: privilege mode never reached %0d", name, mode);
            stop_run();
        end
    endtask

    // Write mstatus with MPP=U then MRET
    task automatic enter_user_mode(input string name, input csr_pkg::xlen_t mst);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, mst, 32'd0);
        run_cmd(csr_pkg::CSR_MRET, 12'h000, 32'd0, 32'd0);
        check_value(name, 32'd1, {31'd0, last_flg});
        wait_mode(name, csr_pkg::U_MODE);
    endtask

    task automatic test_reset_state();
        csr_pkg::xlen_t rd;
        csr_pkg::xlen_t d0;
        csr_pkg::xlen_t d1;
        csr_pkg::xlen_t d2;
        check_value("reset_priv", 32'd3, {30'd0, priv_mode});
        read_csr(csr_pkg::ADDR_MSTATUS, rd);
        check_value("reset_mstatus", 32'h0000_1800, rd); // MPP=M only
        read_csr(csr_pkg::ADDR_MISA, rd);
        check_value("reset_misa", MISA_EXP, rd);
        d0 = $random(seed);
        d1 = $random(seed);
        d2 = $random(seed);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSCRATCH, d0, 32'd0);
        read_csr(csr_pkg::ADDR_MSCRATCH, rd);
        check_value("mscratch_w", d0, rd);
        run_cmd(csr_pkg::CSR_S, csr_pkg::ADDR_MSCRATCH, d1, 32'd0);
        check_value("mscratch_s_old", d0, last_rdata); // Old value returned
        read_csr(csr_pkg::ADDR_MSCRATCH, rd);
        check_value("mscratch_s", d0 | d1, rd);
        run_cmd(csr_pkg::CSR_C, csr_pkg::ADDR_MSCRATCH, d2, 32'd0);
        read_csr(csr_pkg::ADDR_MSCRATCH, rd);
        scratch_exp = (d0 | d1) & ~d2;
        check_value("mscratch_c", scratch_exp, rd);
    endtask

    task automatic test_mret_to_user();
        csr_pkg::xlen_t rd;
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, 32'd0, 32'd0); // MPP=U
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MEPC, 32'h0000_1236, 32'd0);
        run_cmd(csr_pkg::CSR_MRET, 12'h000, 32'd0, 32'd0);
        check_value("mret_flag", 32'd1, {31'd0, last_flg});
        check_value("mret_vector", 32'h0000_1234, last_vec); // Low bits dropped
        wait_mode("mret_mode", csr_pkg::U_MODE);
        read_csr(csr_pkg::ADDR_MSCRATCH, rd);
        check_value("user_read_mscratch", 32'd0, rd);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSCRATCH, ~scratch_exp, 32'd0);
        check_value("user_write_flag", 32'd0, {31'd0, last_flg});
        run_cmd(csr_pkg::CSR_ECALL, 12'h000, 32'd0, 32'h0000_1400); // Back to M
        wait_mode("mret_back_to_m", csr_pkg::M_MODE);
        read_csr(csr_pkg::ADDR_MSCRATCH, rd);
        check_value("user_write_ignored", scratch_exp, rd);
    endtask

    task automatic test_ecall_to_m();
        csr_pkg::xlen_t rd;
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MTVEC, 32'h0000_0400, 32'd0); // Direct
        enter_user_mode("ecall_m_enter", 32'd0);
        run_cmd(csr_pkg::CSR_ECALL, 12'h000, 32'd0, 32'h0000_2000);
        check_value("ecall_m_flag", 32'd1, {31'd0, last_flg});
        check_value("ecall_m_vector", 32'h0000_0400, last_vec);
        wait_mode("ecall_m_mode", csr_pkg::M_MODE);
        read_csr(csr_pkg::ADDR_MCAUSE, rd);
        check_value("ecall_m_mcause", 32'd8, rd); // ECALL from U
        read_csr(csr_pkg::ADDR_MEPC, rd);
        check_value("ecall_m_mepc", 32'h0000_2000, rd);
        read_csr(csr_pkg::ADDR_MSTATUS, rd);
        check_value("ecall_m_mstatus", 32'd0, rd); // MPIE copies the cleared MIE
    endtask

    task automatic test_ecall_to_s();
        csr_pkg::xlen_t rd;
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MEDELEG, 32'h0000_0100, 32'd0);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_STVEC, 32'h0000_0800, 32'd0);
        enter_user_mode("ecall_s_enter", 32'd0);
        run_cmd(csr_pkg::CSR_ECALL, 12'h000, 32'd0, 32'h0000_3000);
        check_value("ecall_s_flag", 32'd1, {31'd0, last_flg});
        check_value("ecall_s_vector", 32'h0000_0800, last_vec);
        wait_mode("ecall_s_mode", csr_pkg::S_MODE);
        read_csr(csr_pkg::ADDR_SCAUSE, rd);
        check_value("ecall_s_scause", 32'd8, rd);
        read_csr(csr_pkg::ADDR_SEPC, rd);
        check_value("ecall_s_sepc", 32'h0000_3000, rd);
        read_csr(csr_pkg::ADDR_SSTATUS, rd);
        check_value("ecall_s_sstatus", 32'd0, rd); // SPP, SPIE and SIE all clear
        run_cmd(csr_pkg::CSR_SRET, 12'h000, 32'd0, 32'd0);
        check_value("sret_flag", 32'd1, {31'd0, last_flg});
        check_value("sret_vector", 32'h0000_3000, last_vec);
        wait_mode("sret_mode", csr_pkg::U_MODE);
        // Delegated ECALL into S and then a non-delegated ECALL from S to M
        run_cmd(csr_pkg::CSR_ECALL, 12'h000, 32'd0, 32'h0000_3100);
        wait_mode("ecall_s_again", csr_pkg::S_MODE);
        run_cmd(csr_pkg::CSR_ECALL, 12'h000, 32'd0, 32'h0000_3200);
        check_value("ecall_from_s_vector", 32'h0000_0400, last_vec);
        wait_mode("ecall_from_s_mode", csr_pkg::M_MODE);
        read_csr(csr_pkg::ADDR_MCAUSE, rd);
        check_value("ecall_from_s_mcause", 32'd9, rd);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MEDELEG, 32'd0, 32'd0);
    endtask

    task automatic test_timer_irq();
        csr_pkg::xlen_t rd;
        mtimecmp = 64'd100;
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MTVEC, 32'h0000_1001, 32'd0); // Vectored
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MIE, 32'h0000_0080, 32'd0);   // MTIE
        enter_user_mode("timer_enter", 32'h0000_0080); // MPIE=1 gives MIE=1 in U
        @(negedge clk);
        mtime = 64'd200; // Compare hits and MTIP follows a cycle later
        run_cmd(csr_pkg::CSR_NONE, 12'h000, 32'd0, 32'h0000_4000);
        check_value("timer_flag", 32'd1, {31'd0, last_flg});
        check_value("timer_vector", 32'h0000_1000 + 32'd4 * 32'd7, last_vec);
        wait_mode("timer_mode", csr_pkg::M_MODE);
        read_csr(csr_pkg::ADDR_MCAUSE, rd);
        check_value("timer_mcause", INTR | 32'd7, rd);
        read_csr(csr_pkg::ADDR_MSTATUS, rd);
        check_value("timer_mstatus", 32'h0000_0080, rd); // MPIE holds the old MIE
        read_csr(csr_pkg::ADDR_MEPC, rd);
        check_value("timer_mepc", 32'h0000_4000, rd);
        @(negedge clk);
        mtime = 64'd0; // Timer quiet again
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MIE, 32'd0, 32'd0);
    endtask

    task automatic test_soft_irq_deleg();
        csr_pkg::xlen_t rd;
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MIDELEG, 32'h0000_0002, 32'd0);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_SIE, 32'h0000_0002, 32'd0);
        run_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_SIP, 32'h0000_0002, 32'd0);
        read_csr(csr_pkg::ADDR_SIP, rd);
        check_value("ssip_pending", 32'h0000_0002, rd);
        enter_user_mode("ssi_enter", 32'd0); // M with MIE=0 never takes it
        run_cmd(csr_pkg::CSR_NONE, 12'h000, 32'd0, 32'h0000_5000);
        check_value("ssi_flag", 32'd1, {31'd0, last_flg});
        check_value("ssi_vector", 32'h0000_0800, last_vec);
        wait_mode("ssi_mode", csr_pkg::S_MODE);
        read_csr(csr_pkg::ADDR_SCAUSE, rd);
        check_value("ssi_scause", INTR | 32'd1, rd);
        read_csr(csr_pkg::ADDR_SIP, rd);
        check_value("ssi_cleared", 32'd0, rd);
        read_csr(csr_pkg::ADDR_SEPC, rd);
        check_value("ssi_sepc", 32'h0000_5000, rd);
    endtask

    initial begin
        seed      = 38694;
        reset     = 1'b1;
        csr_valid = 1'b0;
        csr_cmd   = csr_pkg::CSR_NONE;
        csr_addr  = '0;
        csr_wsrc  = '0;
        csr_pc    = '0;
        mtime     = '0;
        mtimecmp  = '1; // Timer idle
        repeat (16) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_mret_to_user();
        test_ecall_to_m();
        test_ecall_to_s();
        test_timer_irq();
        test_soft_irq_deleg();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: flist.f
csr_pkg.sv
csr_access.sv
trap_ctrl.sv
csr_regs.sv
csr_stage.sv
csr_stage_props.sv
tb_csr_stage.sv
